/* flist.f */
+incdir+.
epb_wb_pkg.sv
epb_wb_bridge.sv
wb_addr_decoder.sv
wb_reg_bank.sv
wb_sram.sv
epb_wb_top.sv
tb_epb_wb_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the epb to wishbone bridge testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module tb_epb_wb_top \
  -f flist.f \
  -o sim_tb_epb_wb_top

./obj_dir/sim_tb_epb_wb_top | tee sim.log

if grep -q "TEST PASS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

/* tb_epb_tasks.svh */
// epb master, shadow models and checks, included inside tb_epb_wb_top

// sram window starts at byte 0x0001_0000, which is halfword 0x8000 on the epb side
localparam logic [22:0] SRAM_HW_BASE = 23'h00_8000;
// bound on a single access in epb cycles, a normal access needs about 15
localparam int RDY_LIMIT = 100;

// scratch shadow, entry 0 unused since register 0 is the id
logic [15:0] scratch_model [8];
// sram shadow indexed by halfword address modulo the depth
logic [15:0] sram_model [1 << SRAM_AW];
// window offsets that hold known data
logic [14:0] sram_pool [$];

task automatic check_value(input logic [15:0] got, input logic [15:0] exp, input string what);
  checks++;
  assert (got === exp) else begin
    $display("[ERROR] %0t ns %s: got %h, expected %h", $time, what, got, exp);
    errors++;
  end
endtask

// only bytes whose be_n bit is low take the new value
function automatic logic [15:0] merge_bytes(input logic [15:0] old, input logic [15:0] wdat,
                                            input logic [1:0] be_n);
  logic [15:0] res;
  res = old;
  if (!be_n[0]) begin
    res[7:0] = wdat[7:0];
  end
  if (!be_n[1]) begin
    res[15:8] = wdat[15:8];
  end
  return res;
endfunction

function automatic int pick_index(input int n);
  return int'($urandom % n);
endfunction

// one access, cs_n goes high for a single cycle first and stays low after ready
task automatic epb_access(input logic r_w_n, input logic [22:0] addr, input logic [5:0] gp,
                          input logic [1:0] be_n, input logic [15:0] wdata,
                          output logic [15:0] rdata);
  int waited;
  waited = 0;
  rdata = 16'h0000;
  @(posedge epb_clk_i);
  epb_cs_n_i    <= 1'b1;
  epb_r_w_n_i   <= r_w_n;
  epb_addr_i    <= addr;
  epb_addr_gp_i <= gp;
  epb_be_n_i    <= be_n;
  epb_data_i    <= wdata;
  @(posedge epb_clk_i);
  epb_cs_n_i <= 1'b0;
  // falling edge seen by the bridge here, ready of the last access clears
  @(posedge epb_clk_i);
  @(negedge epb_clk_i);
  while (!epb_rdy_o && waited < RDY_LIMIT) begin
    check_value(16'(epb_data_oen_o), 16'h0001, "output enable while busy");
    waited++;
    @(negedge epb_clk_i);
  end
  if (!epb_rdy_o) begin
    $display("no ready from bridge for access to gp %h addr %h at %0t ns", gp, addr, $time);
    errors++;
  end else begin
    check_value(16'(epb_data_oen_o), 16'h0000, "output enable at ready");
    rdata = epb_data_o;
  end
endtask

task automatic epb_write(input logic [22:0] addr, input logic [5:0] gp,
                         input logic [1:0] be_n, input logic [15:0] data);
  logic [15:0] unused_rd;
  epb_access(1'b0, addr, gp, be_n, data, unused_rd);
endtask

task automatic epb_read(input logic [22:0] addr, input logic [5:0] gp, output logic [15:0] data);
  epb_access(1'b1, addr, gp, 2'b00, 16'h0000, data);
endtask

// idx is 1 to 7
task automatic scratch_write(input logic [4:0] idx, input logic [1:0] be_n,
                             input logic [15:0] data);
  epb_write({18'd0, idx}, 6'd0, be_n, data);
  scratch_model[idx[2:0]] = merge_bytes(scratch_model[idx[2:0]], data, be_n);
endtask

task automatic sram_write(input logic [14:0] off, input logic [1:0] be_n,
                          input logic [15:0] data);
  epb_write(SRAM_HW_BASE + {8'd0, off}, 6'd0, be_n, data);
  sram_model[off[SRAM_AW-1:0]] = merge_bytes(sram_model[off[SRAM_AW-1:0]], data, be_n);
endtask

task automatic reg_check(input logic [4:0] idx);
  logic [15:0] rd;
  logic [15:0] exp;
  if (idx == 5'd0) begin
    exp = ID_VALUE;
  end else if (idx <= 5'd7) begin
    exp = scratch_model[idx[2:0]];
  end else begin
    // registers 8 to 31 read zero
    exp = 16'h0000;
  end
  epb_read({18'd0, idx}, 6'd0, rd);
  check_value(rd, exp, $sformatf("register %0d", idx));
endtask

task automatic sram_check(input logic [14:0] off);
  logic [15:0] rd;
  epb_read(SRAM_HW_BASE + {8'd0, off}, 6'd0, rd);
  check_value(rd, sram_model[off[SRAM_AW-1:0]], $sformatf("sram offset %h", off));
endtask

/* tb_epb_wb_top.sv */
`timescale 1ns/10ps

module tb_epb_wb_top;

  localparam int SRAM_AW = 10;
  // epb clock period in ns, wishbone runs at 4 ns
  localparam int EPB_PERIOD = 6;
  localparam int RESET_CYCLES = 16;
  // about 120 accesses at under 60 wb cycles each, plus margin
  localparam int TIMEOUT_CYCLES = 20000;
  localparam logic [15:0] ID_VALUE = 16'hb41f;

  logic        wb_clk_i = 1'b0;
  logic        epb_clk_i = 1'b0;
  logic        wb_rst_i;
  logic        epb_cs_n_i;
  logic        epb_r_w_n_i;
  logic [1:0]  epb_be_n_i;
  logic [22:0] epb_addr_i;
  logic [5:0]  epb_addr_gp_i;
  logic [15:0] epb_data_i;
  logic [15:0] epb_data_o;
  logic        epb_data_oen_o;
  logic        epb_rdy_o;

  int errors;
  int checks;

  `include "tb_epb_tasks.svh"

  always #2 wb_clk_i = ~wb_clk_i;
  always #(EPB_PERIOD / 2) epb_clk_i = ~epb_clk_i;

  epb_wb_top #(.SRAM_AW(SRAM_AW)) epb_wb_top_i (
    .wb_clk_i, .wb_rst_i, .epb_clk_i, .epb_cs_n_i, .epb_r_w_n_i, .epb_be_n_i,
    .epb_addr_i, .epb_addr_gp_i, .epb_data_i, .epb_data_o, .epb_data_oen_o, .epb_rdy_o);

  task automatic end_run(input bit hit_timeout);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0 && !hit_timeout) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  endtask

  // ready and output enable stay low through reset and until the first access
  task automatic reset_state_test();
    repeat (RESET_CYCLES / 2) @(posedge wb_clk_i);
    @(negedge epb_clk_i);
    check_value(16'(epb_rdy_o), 16'h0000, "ready during reset");
    check_value(16'(epb_data_oen_o), 16'h0000, "output enable during reset");
    repeat (RESET_CYCLES / 2) @(posedge wb_clk_i);
    wb_rst_i <= 1'b0;
    repeat (4) @(negedge epb_clk_i);
    check_value(16'(epb_rdy_o), 16'h0000, "ready after reset");
    check_value(16'(epb_data_oen_o), 16'h0000, "output enable after reset");
  endtask

  task automatic id_register_test();
    reg_check(5'd0);
    // register 0 ignores writes
    epb_write(23'd0, 6'd0, 2'b00, 16'h1234);
    reg_check(5'd0);
  endtask

  task automatic scratch_test();
    logic [4:0] idx;
    for (int i = 1; i <= 7; i++) begin
      reg_check(5'(i));
    end
    repeat (14) begin
      idx = 5'($urandom % 7) + 5'd1;
      scratch_write(idx, 2'($urandom), 16'($urandom));
      reg_check(idx);
    end
    for (int i = 8; i < 32; i++) begin
      reg_check(5'(i));
    end
  endtask

  task automatic sram_test();
    logic [14:0] off;
    repeat (10) begin
      off = 15'($urandom);
      sram_write(off, 2'b00, 16'($urandom));
      sram_pool.push_back(off);
    end
    repeat (10) begin
      sram_check(sram_pool[pick_index(sram_pool.size())]);
    end
    // byte masks only on words whose both bytes are known
    repeat (8) begin
      off = sram_pool[pick_index(sram_pool.size())];
      sram_write(off, 2'($urandom), 16'($urandom));
      sram_check(off);
    end
    // one depth further in the window lands on the same word
    off = sram_pool[0] ^ 15'(1 << SRAM_AW);
    sram_write(off, 2'b00, 16'h5a3c);
    sram_check(sram_pool[0]);
  endtask

  task automatic unmapped_test();
    logic [15:0] rd;
    scratch_write(5'd1, 2'b00, 16'hc3a5);
    // halfword 0x21 is past the register region but aliases register 1 in the bank
    epb_write(23'h00_0021, 6'd0, 2'b00, 16'hdead);
    // nonzero gp moves an sram offset out of the window
    epb_write(SRAM_HW_BASE + {8'd0, sram_pool[1]}, 6'd1, 2'b00, 16'hbeef);
    reg_check(5'd1);
    sram_check(sram_pool[1]);
    reg_check(5'd0);
    epb_read(23'h00_0040, 6'd0, rd);
    check_value(rd, 16'h0000, "unmapped read after id read");
    sram_check(sram_pool[2]);
    epb_read(SRAM_HW_BASE + {8'd0, sram_pool[2]}, 6'd2, rd);
    check_value(rd, 16'h0000, "unmapped read after sram read");
  endtask

  // every access already uses the minimum gap, here regions alternate
  task automatic back_to_back_test();
    for (int i = 0; i < 4; i++) begin
      scratch_write(5'(i + 2), 2'b00, 16'h1100 + 16'(i));
      sram_write(sram_pool[i], 2'b00, 16'h2200 + 16'(i));
    end
    for (int i = 0; i < 4; i++) begin
      reg_check(5'(i + 2));
      sram_check(sram_pool[i]);
    end
  endtask

  initial begin
    void'($urandom(32'hf1cc73c5));
    errors = 0;
    checks = 0;
    wb_rst_i      <= 1'b1;
    epb_cs_n_i    <= 1'b1;
    epb_r_w_n_i   <= 1'b1;
    epb_be_n_i    <= 2'b00;
    epb_addr_i    <= 23'd0;
    epb_addr_gp_i <= 6'd0;
    epb_data_i    <= 16'h0000;
    for (int i = 0; i < 8; i++) begin
      scratch_model[i] = 16'h0000;
    end
    reset_state_test();
    id_register_test();
    scratch_test();
    sram_test();
    unmapped_test();
    back_to_back_test();
    end_run(1'b0);
  end

  // run limit in wb cycles
  initial begin
    for (int cycle = 0; cycle < TIMEOUT_CYCLES; cycle++) begin
      @(posedge wb_clk_i);
    end
    $display("timeout, run did not finish within %0d wb cycles", TIMEOUT_CYCLES);
    end_run(1'b1);
  end

endmodule

/* epb_wb_top.sv */
`timescale 1ns/10ps

module epb_wb_top #(
  parameter int SRAM_AW = 10
) (
  input  logic                  wb_clk_i,
  input  logic                  wb_rst_i,
  input  logic                  epb_clk_i,
  input  logic                  epb_cs_n_i,
  input  logic                  epb_r_w_n_i,
  input  epb_wb_pkg::wb_sel_t   epb_be_n_i,
  input  epb_wb_pkg::epb_addr_t epb_addr_i,
  input  epb_wb_pkg::epb_gp_t   epb_addr_gp_i,
  input  epb_wb_pkg::wb_data_t  epb_data_i,
  output epb_wb_pkg::wb_data_t  epb_data_o,
  output logic                  epb_data_oen_o,
  output logic                  epb_rdy_o
);

  // master side of the internal bus
  logic                 wb_cyc, wb_stb, wb_we, wb_ack, wb_err;
  epb_wb_pkg::wb_sel_t  wb_sel;
  epb_wb_pkg::wb_addr_t wb_adr;
  epb_wb_pkg::wb_data_t wb_dat_m2s, wb_dat_s2m;

  // per slave strobes and responses
  logic                 reg_stb, reg_ack, ram_stb, ram_ack;
  epb_wb_pkg::wb_data_t reg_dat, ram_dat;

  epb_wb_bridge epb_wb_bridge_i (
    .wb_clk_i, .wb_rst_i, .epb_clk_i, .epb_cs_n_i, .epb_r_w_n_i, .epb_be_n_i,
    .epb_addr_i, .epb_addr_gp_i, .epb_data_i, .epb_data_o, .epb_data_oen_o, .epb_rdy_o,
    .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_sel_o(wb_sel),
    .wb_adr_o(wb_adr), .wb_dat_o(wb_dat_m2s), .wb_dat_i(wb_dat_s2m),
    .wb_ack_i(wb_ack), .wb_err_i(wb_err));

  wb_addr_decoder wb_addr_decoder_i (
    .wb_clk_i, .wb_rst_i, .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_adr_i(wb_adr),
    .wb_dat_o(wb_dat_s2m), .wb_ack_o(wb_ack), .wb_err_o(wb_err),
    .reg_stb_o(reg_stb), .reg_dat_i(reg_dat), .reg_ack_i(reg_ack),
    .ram_stb_o(ram_stb), .ram_dat_i(ram_dat), .ram_ack_i(ram_ack));

  // register bank only decodes the low byte address bits
  wb_reg_bank wb_reg_bank_i (
    .wb_clk_i, .wb_rst_i, .wb_stb_i(reg_stb), .wb_we_i(wb_we), .wb_sel_i(wb_sel),
    .wb_adr_i(wb_adr[5:0]), .wb_dat_i(wb_dat_m2s), .wb_dat_o(reg_dat), .wb_ack_o(reg_ack));

  wb_sram #(.SRAM_AW(SRAM_AW)) wb_sram_i (
    .wb_clk_i, .wb_rst_i, .wb_stb_i(ram_stb), .wb_we_i(wb_we), .wb_sel_i(wb_sel),
    .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_m2s), .wb_dat_o(ram_dat), .wb_ack_o(ram_ack));

endmodule

/* wb_sram.sv */
`timescale 1ns/10ps

module wb_sram #(
  parameter int SRAM_AW = 10
) (
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  epb_wb_pkg::wb_sel_t  wb_sel_i,
  input  epb_wb_pkg::wb_addr_t wb_adr_i,
  input  epb_wb_pkg::wb_data_t wb_dat_i,
  output epb_wb_pkg::wb_data_t wb_dat_o,
  output logic                 wb_ack_o
);

  localparam int DEPTH = 1 << SRAM_AW;

  epb_wb_pkg::wb_data_t mem [DEPTH];

  logic [SRAM_AW-1:0] addr;
  logic               acked;
  logic               take;

  // halfword address, upper window bits ignored so the array aliases
  assign addr = wb_adr_i[SRAM_AW:1];
  assign take = wb_stb_i & ~acked;

  // single port ram with byte enables and registered read
  always_ff @(posedge wb_clk_i) begin
    if (take) begin
      if (wb_we_i && wb_sel_i[0]) begin
        mem[addr][7:0] <= wb_dat_i[7:0];
      end
      if (wb_we_i && wb_sel_i[1]) begin
        mem[addr][15:8] <= wb_dat_i[15:8];
      end
      wb_dat_o <= mem[addr];
    end
  end

  // one ack per strobe
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      acked    <= 1'b0;
      wb_ack_o <= 1'b0;
    end else begin
      acked    <= wb_stb_i;
      wb_ack_o <= take;
    end
  end

  a_ack_after_stb: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_o |-> $past(wb_stb_i));

endmodule

/* wb_reg_bank.sv */
`timescale 1ns/10ps

module wb_reg_bank (
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  epb_wb_pkg::wb_sel_t  wb_sel_i,
  input  logic [5:0]           wb_adr_i,
  input  epb_wb_pkg::wb_data_t wb_dat_i,
  output epb_wb_pkg::wb_data_t wb_dat_o,
  output logic                 wb_ack_o
);

  // halfword index, 32 locations
  logic [4:0] idx;
  logic       acked;
  logic       take;
  logic       scratch_hit;

  epb_wb_pkg::wb_data_t scratch [1:7];
  epb_wb_pkg::wb_data_t rd_val;

  assign idx = wb_adr_i[5:1];

  // first cycle of a strobe only
  assign take = wb_stb_i & ~acked;

  // registers 1 to 7
  assign scratch_hit = (idx[4:3] == 2'b00) && (idx[2:0] != 3'd0);

  always_comb begin
    if (idx == 5'd0) begin
      rd_val = epb_wb_pkg::BRIDGE_ID;
    end else if (scratch_hit) begin
      rd_val = scratch[idx[2:0]];
    end else begin
      // upper locations read as zero
      rd_val = '0;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      acked    <= 1'b0;
      wb_ack_o <= 1'b0;
      for (int i = 1; i <= 7; i++) begin
        scratch[i] <= '0;
      end
    end else begin
      // acked stays high while the master holds stb
      acked    <= wb_stb_i;
      wb_ack_o <= take;
      // register 0 is read only, writes to it are dropped
      if (take && wb_we_i && scratch_hit) begin
        if (wb_sel_i[0]) begin
          scratch[idx[2:0]][7:0] <= wb_dat_i[7:0];
        end
        if (wb_sel_i[1]) begin
          scratch[idx[2:0]][15:8] <= wb_dat_i[15:8];
        end
      end
    end
  end

  // read data lines up with ack
  always_ff @(posedge wb_clk_i) begin
    if (take) begin
      wb_dat_o <= rd_val;
    end
  end

endmodule

/* wb_addr_decoder.sv */
`timescale 1ns/10ps

module wb_addr_decoder (
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  epb_wb_pkg::wb_addr_t wb_adr_i,
  output epb_wb_pkg::wb_data_t wb_dat_o,
  output logic                 wb_ack_o,
  output logic                 wb_err_o,
  output logic                 reg_stb_o,
  input  epb_wb_pkg::wb_data_t reg_dat_i,
  input  logic                 reg_ack_i,
  output logic                 ram_stb_o,
  input  epb_wb_pkg::wb_data_t ram_dat_i,
  input  logic                 ram_ack_i
);

  logic bus_req;
  logic reg_hit;
  logic ram_hit;
  logic err_q;

  assign bus_req = wb_cyc_i & wb_stb_i;

  // regions are size aligned, so masking off the offset is enough
  assign reg_hit = (wb_adr_i & ~(epb_wb_pkg::REG_REGION_BYTES - 1)) == epb_wb_pkg::REG_BASE;
  assign ram_hit = (wb_adr_i & ~(epb_wb_pkg::SRAM_REGION_BYTES - 1)) == epb_wb_pkg::SRAM_BASE;

  // only the selected slave sees stb
  assign reg_stb_o = bus_req & reg_hit;
  assign ram_stb_o = bus_req & ram_hit;

  // unmapped access, one cycle err after stb
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= bus_req && !reg_hit && !ram_hit && !err_q;
    end
  end

  assign wb_err_o = err_q;
  assign wb_ack_o = reg_ack_i | ram_ack_i;

  // return data from whichever slave acked
  always_comb begin
    if (reg_ack_i) begin
      wb_dat_o = reg_dat_i;
    end else if (ram_ack_i) begin
      wb_dat_o = ram_dat_i;
    end else begin
      wb_dat_o = '0;
    end
  end

  a_ack_err: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    !(wb_ack_o && wb_err_o));

endmodule

/* epb_wb_bridge.sv */
`timescale 1ns/10ps

module epb_wb_bridge (
  input  logic                  wb_clk_i,
  input  logic                  wb_rst_i,
  input  logic                  epb_clk_i,
  input  logic                  epb_cs_n_i,
  input  logic                  epb_r_w_n_i,
  input  epb_wb_pkg::wb_sel_t   epb_be_n_i,
  input  epb_wb_pkg::epb_addr_t epb_addr_i,
  input  epb_wb_pkg::epb_gp_t   epb_addr_gp_i,
  input  epb_wb_pkg::wb_data_t  epb_data_i,
  output epb_wb_pkg::wb_data_t  epb_data_o,
  output logic                  epb_data_oen_o,
  output logic                  epb_rdy_o,
  output logic                  wb_cyc_o,
  output logic                  wb_stb_o,
  output logic                  wb_we_o,
  output epb_wb_pkg::wb_sel_t   wb_sel_o,
  output epb_wb_pkg::wb_addr_t  wb_adr_o,
  output epb_wb_pkg::wb_data_t  wb_dat_o,
  input  epb_wb_pkg::wb_data_t  wb_dat_i,
  input  logic                  wb_ack_i,
  input  logic                  wb_err_i
);

  // epb domain control
  logic prev_cs_n;
  logic cs_fall;
  logic busy;
  logic cmd_sent;

  // latched command, held until the response comes back
  logic                  cmd_r_w_n;
  epb_wb_pkg::wb_sel_t   cmd_be_n;
  epb_wb_pkg::epb_addr_t cmd_addr;
  epb_wb_pkg::epb_gp_t   cmd_gp;
  epb_wb_pkg::wb_data_t  cmd_dat;

  // handshake levels and their synchronizers
  logic cmd_req, cmd_req_q1, cmd_req_s;
  logic cmd_ack, cmd_ack_q1, cmd_ack_s;
  logic resp_req, resp_req_q1, resp_req_s;
  logic resp_ack, resp_ack_q1, resp_ack_s;

  // wishbone domain
  epb_wb_pkg::wb_state_t state;
  epb_wb_pkg::wb_data_t  rsp_dat;

  assign cs_fall = prev_cs_n & ~epb_cs_n_i;

  // command fields cross unsynchronized, they are stable for the whole access
  assign wb_adr_o = {2'b00, cmd_gp, cmd_addr, 1'b0};
  assign wb_sel_o = ~cmd_be_n;
  assign wb_we_o  = ~cmd_r_w_n;
  assign wb_dat_o = cmd_dat;

  // epb side sequencing
  always_ff @(posedge epb_clk_i) begin
    if (wb_rst_i) begin
      prev_cs_n      <= 1'b1;
      busy           <= 1'b0;
      cmd_sent       <= 1'b0;
      cmd_req        <= 1'b0;
      resp_ack       <= 1'b0;
      epb_rdy_o      <= 1'b0;
      epb_data_oen_o <= 1'b0;
    end else begin
      prev_cs_n <= epb_cs_n_i;
      // response ack simply follows the synchronized request
      resp_ack <= resp_req_s;
      // request drops as soon as the wb side has seen it
      if (cmd_req && cmd_ack_s) begin
        cmd_req <= 1'b0;
      end else if (busy && !cmd_sent && !cmd_ack_s) begin
        // previous ack still high at latch time, raise request once it clears
        cmd_req  <= 1'b1;
        cmd_sent <= 1'b1;
      end
      // ready is held until the next access starts
      if (cs_fall) begin
        epb_rdy_o <= 1'b0;
      end
      if (cs_fall && !busy) begin
        busy           <= 1'b1;
        cmd_req        <= !cmd_ack_s;
        cmd_sent       <= !cmd_ack_s;
        epb_data_oen_o <= 1'b1;
      end
      // rising edge of the synchronized response ends the access
      if (resp_req_s && !resp_ack) begin
        busy           <= 1'b0;
        epb_rdy_o      <= 1'b1;
        epb_data_oen_o <= 1'b0;
      end
    end
  end

  // epb payload
  always_ff @(posedge epb_clk_i) begin
    if (cs_fall && !busy) begin
      cmd_r_w_n <= epb_r_w_n_i;
      cmd_be_n  <= epb_be_n_i;
      cmd_addr  <= epb_addr_i;
      cmd_gp    <= epb_addr_gp_i;
      cmd_dat   <= epb_data_i;
    end
    // rsp_dat has been stable since before resp_req rose
    if (resp_req_s && !resp_ack) begin
      epb_data_o <= rsp_dat;
    end
  end

  // two flop synchronizers into the epb domain
  always_ff @(posedge epb_clk_i) begin
    if (wb_rst_i) begin
      cmd_ack_q1  <= 1'b0;
      cmd_ack_s   <= 1'b0;
      resp_req_q1 <= 1'b0;
      resp_req_s  <= 1'b0;
    end else begin
      cmd_ack_q1  <= cmd_ack;
      cmd_ack_s   <= cmd_ack_q1;
      resp_req_q1 <= resp_req;
      resp_req_s  <= resp_req_q1;
    end
  end

  // two flop synchronizers into the wb domain
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      cmd_req_q1  <= 1'b0;
      cmd_req_s   <= 1'b0;
      resp_ack_q1 <= 1'b0;
      resp_ack_s  <= 1'b0;
    end else begin
      cmd_req_q1  <= cmd_req;
      cmd_req_s   <= cmd_req_q1;
      resp_ack_q1 <= resp_ack;
      resp_ack_s  <= resp_ack_q1;
    end
  end

  // wishbone master fsm
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state    <= epb_wb_pkg::WB_IDLE;
      wb_cyc_o <= 1'b0;
      wb_stb_o <= 1'b0;
      cmd_ack  <= 1'b0;
      resp_req <= 1'b0;
    end else begin
      // release the command ack once the request is gone
      if (!cmd_req_s) begin
        cmd_ack <= 1'b0;
      end
      case (state)
        epb_wb_pkg::WB_IDLE: begin
          if (cmd_req_s && !cmd_ack) begin
            cmd_ack  <= 1'b1;
            wb_cyc_o <= 1'b1;
            wb_stb_o <= 1'b1;
            state    <= epb_wb_pkg::WB_BUS;
          end
        end
        epb_wb_pkg::WB_BUS: begin
          // classic cycle, hold cyc and stb until the slave answers
          if (wb_ack_i || wb_err_i) begin
            wb_cyc_o <= 1'b0;
            wb_stb_o <= 1'b0;
            resp_req <= 1'b1;
            state    <= epb_wb_pkg::WB_WAIT_REQ;
          end
        end
        epb_wb_pkg::WB_WAIT_REQ: begin
          if (resp_ack_s) begin
            resp_req <= 1'b0;
            state    <= epb_wb_pkg::WB_WAIT_DROP;
          end
        end
        epb_wb_pkg::WB_WAIT_DROP: begin
          if (!resp_ack_s && !cmd_ack) begin
            state <= epb_wb_pkg::WB_IDLE;
          end
        end
        default: state <= epb_wb_pkg::WB_IDLE;
      endcase
    end
  end

  // read data, forced to zero on a bus error
  always_ff @(posedge wb_clk_i) begin
    if (state == epb_wb_pkg::WB_BUS && (wb_ack_i || wb_err_i)) begin
      rsp_dat <= wb_ack_i ? wb_dat_i : '0;
    end
  end

  a_stb_cyc: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_stb_o == wb_cyc_o);

  // cycle may only end on a slave response
  a_cyc_end: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    $fell(wb_cyc_o) |-> $past(wb_ack_i || wb_err_i) && state == epb_wb_pkg::WB_WAIT_REQ);

  // a second access started before ready is lost
  a_no_overlap: assert property (@(posedge epb_clk_i) disable iff (wb_rst_i)
    cs_fall |-> !busy);

endmodule

/* epb_wb_pkg.sv */
package epb_wb_pkg;

  // data word, identical on the epb and wishbone sides
  typedef logic [15:0] wb_data_t;

  // byte select, bit 1 picks the high byte
  typedef logic [1:0] wb_sel_t;

  // wishbone byte address
  typedef logic [31:0] wb_addr_t;

  // epb halfword address and general purpose upper bits
  typedef logic [22:0] epb_addr_t;
  typedef logic [5:0] epb_gp_t;

  // region 0, register bank with 32 halfwords
  localparam wb_addr_t REG_BASE = 32'h0000_0000;
  localparam wb_addr_t REG_REGION_BYTES = 32'h0000_0040;

  // region 1, sram window
  localparam wb_addr_t SRAM_BASE = 32'h0001_0000;
  localparam wb_addr_t SRAM_REGION_BYTES = 32'h0001_0000;

  // value returned by register 0
  localparam wb_data_t BRIDGE_ID = 16'hb41f;

  // wishbone side of the bridge
  // idle: wait for a synchronized command request
  // bus: classic cycle in progress
  // wait_req: response request raised, waiting for its ack
  // wait_drop: waiting for both handshakes to return to zero
  typedef enum logic [1:0] {
    WB_IDLE,
    WB_WAIT_REQ,
    WB_BUS,
    WB_WAIT_DROP
  } wb_state_t;

endpackage
